// File: bootMemTop.f
design/memMapPkg.sv
design/bootPkg.sv
design/bootLoader.sv
design/bankRouter.sv
design/ramBank.sv
design/readCollector.sv
design/bootMemTop.sv
verif/sdCardModel.sv
verif/bootMemTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f bootMemTop.f --top-module bootMemTb \
    -Mdir obj_dir -o simBootMem || exit 1
./obj_dir/simBootMem > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || exit 1
echo "Simulation finished without errors"

// File: verif/bootMemTb.sv
module bootMemTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ClockPeriod = 40;
    localparam int ProgramWords = 40;
    localparam int RandomCycles = 300;
    localparam int RamWords = memMapPkg::NumBanks * memMapPkg::BankWords;
    // Request, rise, six busy cycles, capture and write for each SD word
    localparam int SdWordCycles = 10;
    localparam int BootCycles = bootPkg::ResetHoldCycles + (ProgramWords + 1) * SdWordCycles;
    localparam int CpuCycles = ProgramWords + 64 + RandomCycles + 40;
    localparam int WatchdogCycles = 2 * (2 * BootCycles + CpuCycles);

    logic clk_25mhz;
    logic reset;
    logic sdBusy;
    logic [memMapPkg::WordBits-1:0] sdData;
    logic sdRead;
    logic [bootPkg::SdAddrBits-1:0] sdAddress;
    memMapPkg::cpuAddressT cpuAddress;
    logic cpuWrite;
    logic cpuRead;
    logic [memMapPkg::WordBits-1:0] cpuWriteData;
    logic [memMapPkg::WordBits-1:0] cpuReadData;
    logic cpuReadValid;
    logic cpuReset;
    logic bootDone;
    logic pixelWrite;
    logic [7:0] pixelX;
    logic [7:0] pixelY;
    logic [7:0] pixelColor;

    // Shadow RAM plus a flag for words that hold a known value
    logic [memMapPkg::WordBits-1:0] shadow [RamWords];
    bit known [RamWords];
    logic [memMapPkg::WordBits:0] readQueue [$];
    int issueCycles [$];
    int cycleCount = 0;
    int sdReadsExpected;
    int sdReadsSeen;
    logic pixelPending;
    logic [23:0] pixelExpected;
    logic lastBootDone;
    bit resetSeen = 1'b0;

    bootMemTop i_dut (.*);
    sdCardModel sdModel (.*);

    initial begin
        clk_25mhz = 1'b0;
        forever #(ClockPeriod / 2) clk_25mhz = ~clk_25mhz;
    end

    task automatic reportError(input string what);
        $display("error at %0d ns: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic driveCycle(input logic [31:0] address, input logic write, input logic read,
                              input logic [31:0] data);
        @(posedge clk_25mhz);
        cpuAddress <= address;
        cpuWrite <= write;
        cpuRead <= read;
        cpuWriteData <= data;
    endtask

    task automatic applyReset();
        reset <= 1'b1;
        repeat (3) @(posedge clk_25mhz);
        reset <= 1'b0;
    endtask

    // Word 0 holds the count and words 1 to N land at RAM 0 to N-1
    task automatic prepareImage(input int count);
        sdModel.image[0] = count;
        sdModel.busyLen[0] = $urandom_range(6, 1);
        for (int i = 1; i <= count; i++) begin
            sdModel.image[i] = $urandom;
            sdModel.busyLen[i] = $urandom_range(6, 1);
            shadow[i - 1] = sdModel.image[i];
            known[i - 1] = 1'b1;
        end
        sdReadsExpected = count + 1;
    endtask

    task automatic drainReads();
        repeat (2) driveCycle('0, 1'b0, 1'b0, '0);
        while (readQueue.size() != 0) begin
            driveCycle('0, 1'b0, 1'b0, '0);
        end
    endtask

    always @(posedge clk_25mhz) begin : monitor
        memMapPkg::cpuAddressT addr;
        logic [memMapPkg::RamAddrBits-1:0] idx;
        logic [memMapPkg::WordBits:0] expected;
        int issued;
        cycleCount++;
        addr = cpuAddress;
        idx = addr[memMapPkg::RamAddrBits-1:0];
        if (reset) begin
            resetSeen = 1'b1;
            readQueue.delete();
            issueCycles.delete();
            pixelPending = 1'b0;
            lastBootDone = 1'b0;
            sdReadsSeen = 0;
        end else if (resetSeen) begin
            assert (cpuReset === !bootDone)
                else reportError($sformatf("cpuReset %b with bootDone %b", cpuReset, bootDone));
            assert (bootDone || !lastBootDone) else reportError("bootDone fell without a reset");
            assert (!(sdRead && sdBusy)) else reportError("sdRead pulsed while sdBusy was high");
            // SD words are requested in order from address zero
            if (sdRead) begin
                assert (sdAddress === bootPkg::SdAddrBits'(sdReadsSeen))
                    else reportError($sformatf("sdAddress %0d on SD read %0d, expected %0d",
                                               sdAddress, sdReadsSeen, sdReadsSeen));
                sdReadsSeen++;
            end else if (sdReadsSeen != 0) begin
                assert (sdAddress === bootPkg::SdAddrBits'(sdReadsSeen - 1))
                    else reportError($sformatf("sdAddress %0d between requests, expected %0d",
                                               sdAddress, sdReadsSeen - 1));
            end
            if (bootDone && !lastBootDone) begin
                assert (sdModel.readCount == sdReadsExpected)
                    else reportError($sformatf("boot ended after %0d SD reads, expected %0d",
                                               sdModel.readCount, sdReadsExpected));
            end
            assert (pixelWrite === pixelPending)
                else reportError($sformatf("pixelWrite %b, expected %b", pixelWrite, pixelPending));
            if (pixelPending) begin
                assert ({pixelX, pixelY, pixelColor} === pixelExpected)
                    else reportError($sformatf("pixel x/y/color %h, expected %h",
                                               {pixelX, pixelY, pixelColor}, pixelExpected));
            end
            if (cpuReadValid) begin
                assert (issueCycles.size() != 0) else reportError("cpuReadValid with no read in flight");
                issued = issueCycles.pop_front();
                expected = readQueue.pop_front();
                assert (cycleCount == issued + 2)
                    else reportError($sformatf("read data after %0d cycles", cycleCount - issued));
                assert (!expected[memMapPkg::WordBits] ||
                        cpuReadData === expected[memMapPkg::WordBits-1:0])
                    else reportError($sformatf("cpuReadData %h, expected %h", cpuReadData,
                                               expected[memMapPkg::WordBits-1:0]));
            end else if (issueCycles.size() != 0) begin
                assert (cycleCount < issueCycles[0] + 2)
                    else reportError("cpuReadValid missing two cycles after cpuRead");
            end
            pixelPending = 1'b0;
            if (!cpuReset) begin
                // Read sees the old word before a same-cycle write lands
                if (cpuRead) begin
                    readQueue.push_back({known[idx], shadow[idx]});
                    issueCycles.push_back(cycleCount);
                end
                if (cpuWrite && addr.mem.upper == '0) begin
                    shadow[idx] = cpuWriteData;
                    known[idx] = 1'b1;
                end
                if (cpuWrite && addr.pixel.low == '0) begin
                    pixelPending = 1'b1;
                    pixelExpected = {addr.pixel.x, addr.pixel.y, cpuWriteData[7:0]};
                end
            end
            lastBootDone = bootDone;
        end
    end

    initial begin : watchdog
        #(WatchdogCycles * ClockPeriod);
        $display("Timeout: the run did not finish within %0d clock cycles", WatchdogCycles);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    initial begin : stimulus
        logic [9:0] index;
        logic [31:0] address;
        void'($urandom(32'h4398_1626));
        reset = 1'b1;
        cpuAddress = '0;
        cpuWrite = 1'b0;
        cpuRead = 1'b0;
        cpuWriteData = '0;

        // Full image while the loader ignores CPU strobes
        prepareImage(ProgramWords);
        applyReset();
        while (!bootDone) begin
            driveCycle(32'($urandom_range(ProgramWords - 1, 0)), 1'b1, 1'($urandom), $urandom);
        end
        for (int i = 0; i < ProgramWords; i++) begin
            driveCycle(32'(i), 1'b0, 1'b1, '0);
        end

        // Random traffic with aliasing, pixel and zero addresses mixed in
        for (int i = 0; i < RandomCycles; i++) begin
            index = ($urandom_range(1, 0) == 0) ? 10'($urandom) : 10'($urandom_range(63, 0));
            address = {16'h0, 6'($urandom), index};
            case ($urandom_range(9, 0))
                8: address = {8'($urandom), 8'($urandom), 16'h0};
                9: address = '0;
                default: ;
            endcase
            driveCycle(address, 1'($urandom), 1'($urandom), $urandom);
        end

        // Pixel only, RAM only, then both at address zero
        driveCycle({8'h5a, 8'h3c, 16'h0}, 1'b1, 1'b0, 32'h1234_56a7);
        driveCycle('0, 1'b0, 1'b1, '0);
        driveCycle(32'h0000_0005, 1'b1, 1'b0, 32'hcafe_0005);
        driveCycle('0, 1'b1, 1'b0, 32'h0bad_f00d);
        driveCycle('0, 1'b0, 1'b1, '0);
        driveCycle(32'h0000_0005, 1'b0, 1'b1, '0);
        drainReads();

        // Empty image on a second boot keeps the RAM contents
        prepareImage(0);
        applyReset();
        while (!bootDone) begin
            driveCycle(32'($urandom_range(63, 0)), 1'b1, 1'($urandom), $urandom);
        end
        for (int i = 0; i < 64; i++) begin
            driveCycle(32'(i), 1'b0, 1'b1, '0);
        end
        drainReads();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verif/sdCardModel.sv
module sdCardModel (
    input  logic clk_25mhz,
    input  logic reset,
    input  logic sdRead,
    input  logic [bootPkg::SdAddrBits-1:0] sdAddress,
    output logic sdBusy,
    output logic [memMapPkg::WordBits-1:0] sdData
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ImageWords = 64;
    localparam int WordSelBits = $clog2(ImageWords);

    // Program image and busy time per word, both filled by the testbench
    logic [memMapPkg::WordBits-1:0] image [ImageWords];
    int busyLen [ImageWords];
    int readCount;

    logic busyReg;
    logic [memMapPkg::WordBits-1:0] dataReg;
    logic [WordSelBits-1:0] wordSel;
    int busyLeft;

    // Reader looks idle while reset is held
    assign sdBusy = busyReg && !reset;
    assign sdData = reset ? '0 : dataReg;

    always @(posedge clk_25mhz) begin
        if (reset) begin
            busyReg <= 1'b0;
            busyLeft <= 0;
            readCount <= 0;
        end else if (sdRead) begin
            // Busy rises the cycle after the request
            busyReg <= 1'b1;
            wordSel <= sdAddress[WordSelBits-1:0];
            busyLeft <= busyLen[sdAddress[WordSelBits-1:0]];
        end else if (busyReg) begin
            if (busyLeft <= 1) begin
                busyReg <= 1'b0;
                dataReg <= image[wordSel];
                readCount <= readCount + 1;
            end else begin
                busyLeft <= busyLeft - 1;
            end
        end
    end

endmodule

// File: design/bootMemTop.sv
module bootMemTop (
    input  logic clk_25mhz,
    input  logic reset,
    input  logic sdBusy,
    input  logic [memMapPkg::WordBits-1:0] sdData,
    output logic sdRead,
    output logic [bootPkg::SdAddrBits-1:0] sdAddress,
    input  memMapPkg::cpuAddressT cpuAddress,
    input  logic cpuWrite,
    input  logic cpuRead,
    input  logic [memMapPkg::WordBits-1:0] cpuWriteData,
    output logic [memMapPkg::WordBits-1:0] cpuReadData,
    output logic cpuReadValid,
    output logic cpuReset,
    output logic bootDone,
    output logic pixelWrite,
    output logic [7:0] pixelX,
    output logic [7:0] pixelY,
    output logic [7:0] pixelColor
);

    // Loader to router
    logic loadWrite;
    logic [memMapPkg::RamAddrBits-1:0] loadIndex;
    logic [memMapPkg::WordBits-1:0] loadData;

    // Router to banks and collector
    logic [memMapPkg::NumBanks-1:0] bankWrite;
    logic [memMapPkg::BankIndexBits-1:0] bankIndex;
    logic [memMapPkg::WordBits-1:0] bankWriteData;
    logic readIssue;
    logic [memMapPkg::BankSelBits-1:0] readBank;
    logic [memMapPkg::WordBits-1:0] bankData [memMapPkg::NumBanks];

    bootLoader loader (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .sdBusy(sdBusy),
        .sdData(sdData),
        .sdRead(sdRead),
        .sdAddress(sdAddress),
        .loadWrite(loadWrite),
        .loadIndex(loadIndex),
        .loadData(loadData),
        .cpuReset(cpuReset),
        .bootDone(bootDone)
    );

    bankRouter router (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .cpuReset(cpuReset),
        .loadWrite(loadWrite),
        .loadIndex(loadIndex),
        .loadData(loadData),
        .cpuAddress(cpuAddress),
        .cpuWrite(cpuWrite),
        .cpuRead(cpuRead),
        .cpuWriteData(cpuWriteData),
        .bankWrite(bankWrite),
        .bankIndex(bankIndex),
        .bankWriteData(bankWriteData),
        .readIssue(readIssue),
        .readBank(readBank),
        .pixelWrite(pixelWrite),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor)
    );

    // Word-interleaved banks, all reading the same index
    for (genvar b = 0; b < memMapPkg::NumBanks; b++) begin : gBank
        ramBank bank (
            .clk_25mhz(clk_25mhz),
            .write(bankWrite[b]),
            .index(bankIndex),
            .writeData(bankWriteData),
            .readData(bankData[b])
        );
    end

    readCollector collector (
        .clk_25mhz(clk_25mhz),
        .reset(reset),
        .readIssue(readIssue),
        .readBank(readBank),
        .bankData(bankData),
        .cpuReadValid(cpuReadValid),
        .cpuReadData(cpuReadData)
    );

endmodule

// File: design/readCollector.sv
module readCollector (
    input  logic clk_25mhz,
    input  logic reset,
    input  logic readIssue,
    input  logic [memMapPkg::BankSelBits-1:0] readBank,
    input  logic [memMapPkg::WordBits-1:0] bankData [memMapPkg::NumBanks],
    output logic cpuReadValid,
    output logic [memMapPkg::WordBits-1:0] cpuReadData
);

    // First stage lines up with the bank output register
    logic issueStage;
    logic [memMapPkg::BankSelBits-1:0] bankStage;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            issueStage <= 1'b0;
            cpuReadValid <= 1'b0;
        end else begin
            issueStage <= readIssue;
            cpuReadValid <= issueStage;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        bankStage <= readBank;
        cpuReadData <= bankData[bankStage];
    end

    // Fixed two-cycle read latency from the CPU strobe
    assert property (@(posedge clk_25mhz) disable iff (reset) readIssue |-> ##2 cpuReadValid);
    assert property (@(posedge clk_25mhz) disable iff (reset)
        cpuReadValid |-> $past(readIssue, 2));

endmodule

// File: design/ramBank.sv
module ramBank (
    input  logic clk_25mhz,
    input  logic write,
    input  logic [memMapPkg::BankIndexBits-1:0] index,
    input  logic [memMapPkg::WordBits-1:0] writeData,
    output logic [memMapPkg::WordBits-1:0] readData
);

    logic [memMapPkg::WordBits-1:0] mem [memMapPkg::BankWords];

    // Registered read returns the old word on a same-index write
    always_ff @(posedge clk_25mhz) begin
        if (write) begin
            mem[index] <= writeData;
        end
        readData <= mem[index];
    end

    // Router must hand over a clean index with each write
    assert property (@(posedge clk_25mhz) write |-> !$isunknown(index));

endmodule

// File: design/bankRouter.sv
module bankRouter (
    input  logic clk_25mhz,
    input  logic reset,
    input  logic cpuReset,
    input  logic loadWrite,
    input  logic [memMapPkg::RamAddrBits-1:0] loadIndex,
    input  logic [memMapPkg::WordBits-1:0] loadData,
    input  memMapPkg::cpuAddressT cpuAddress,
    input  logic cpuWrite,
    input  logic cpuRead,
    input  logic [memMapPkg::WordBits-1:0] cpuWriteData,
    output logic [memMapPkg::NumBanks-1:0] bankWrite,
    output logic [memMapPkg::BankIndexBits-1:0] bankIndex,
    output logic [memMapPkg::WordBits-1:0] bankWriteData,
    output logic readIssue,
    output logic [memMapPkg::BankSelBits-1:0] readBank,
    output logic pixelWrite,
    output logic [7:0] pixelX,
    output logic [7:0] pixelY,
    output logic [7:0] pixelColor
);

    logic ramHit;
    logic pixelHit;

    // Both decodes can hit, address zero writes RAM and a pixel
    assign ramHit = cpuAddress.mem.upper == '0;
    assign pixelHit = cpuAddress.pixel.low == '0;

    always_comb begin
        bankWrite = '0;
        readBank = cpuAddress.mem.bank;
        readIssue = cpuRead && !cpuReset;
        if (cpuReset) begin
            // Loader owns the banks during boot
            bankIndex = loadIndex[memMapPkg::RamAddrBits-1:memMapPkg::BankSelBits];
            bankWriteData = loadData;
            bankWrite[loadIndex[memMapPkg::BankSelBits-1:0]] = loadWrite;
        end else begin
            bankIndex = cpuAddress.mem.index;
            bankWriteData = cpuWriteData;
            bankWrite[cpuAddress.mem.bank] = cpuWrite && ramHit;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            pixelWrite <= 1'b0;
        end else begin
            pixelWrite <= cpuWrite && pixelHit && !cpuReset;
        end
    end

    // Pixel payload for the framebuffer
    always_ff @(posedge clk_25mhz) begin
        if (cpuWrite && pixelHit) begin
            pixelX <= cpuAddress.pixel.x;
            pixelY <= cpuAddress.pixel.y;
            pixelColor <= cpuWriteData[7:0];
        end
    end

    assert property (@(posedge clk_25mhz) disable iff (reset) $onehot0(bankWrite));

endmodule

// File: design/bootLoader.sv
module bootLoader (
    input  logic clk_25mhz,
    input  logic reset,
    input  logic sdBusy,
    input  logic [memMapPkg::WordBits-1:0] sdData,
    output logic sdRead,
    output logic [bootPkg::SdAddrBits-1:0] sdAddress,
    output logic loadWrite,
    output logic [memMapPkg::RamAddrBits-1:0] loadIndex,
    output logic [memMapPkg::WordBits-1:0] loadData,
    output logic cpuReset,
    output logic bootDone
);

    bootPkg::loaderStateT state;
    logic [bootPkg::HoldCountBits-1:0] holdCount;
    logic waitHigh;
    logic [memMapPkg::WordBits-1:0] remaining;
    logic [memMapPkg::RamAddrBits-1:0] ramIndex;
    logic wordArrived;

    // Program word valid after busy was seen high then low
    assign wordArrived = (state == bootPkg::WaitWord) && !waitHigh && !sdBusy;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            state <= bootPkg::Hold;
            holdCount <= '0;
            waitHigh <= 1'b1;
            sdRead <= 1'b0;
            sdAddress <= '0;
            loadWrite <= 1'b0;
            ramIndex <= '0;
            remaining <= '0;
            cpuReset <= 1'b1;
            bootDone <= 1'b0;
        end else begin
            // Strobes are single cycle
            sdRead <= 1'b0;
            loadWrite <= 1'b0;

            case (state)
                bootPkg::Hold: begin
                    if (holdCount == bootPkg::HoldCountBits'(bootPkg::ResetHoldCycles - 1)) begin
                        state <= bootPkg::ReadSize;
                    end else begin
                        holdCount <= holdCount + 1'b1;
                    end
                end
                bootPkg::ReadSize: begin
                    if (!sdBusy) begin
                        sdRead <= 1'b1;
                        waitHigh <= 1'b1;
                        state <= bootPkg::WaitSize;
                    end
                end
                bootPkg::WaitSize: begin
                    if (waitHigh) begin
                        if (sdBusy) begin
                            waitHigh <= 1'b0;
                        end
                    end else if (!sdBusy) begin
                        remaining <= sdData;
                        // Empty image goes straight to release
                        state <= (sdData == '0) ? bootPkg::Finish : bootPkg::ReadWord;
                    end
                end
                bootPkg::ReadWord: begin
                    if (!sdBusy) begin
                        // Address steps with the request and holds until the next one
                        sdRead <= 1'b1;
                        sdAddress <= sdAddress + 1'b1;
                        waitHigh <= 1'b1;
                        state <= bootPkg::WaitWord;
                    end
                end
                bootPkg::WaitWord: begin
                    if (waitHigh) begin
                        if (sdBusy) begin
                            waitHigh <= 1'b0;
                        end
                    end else if (!sdBusy) begin
                        loadWrite <= 1'b1;
                        ramIndex <= ramIndex + 1'b1;
                        remaining <= remaining - 1'b1;
                        state <= (remaining == 1) ? bootPkg::Finish : bootPkg::ReadWord;
                    end
                end
                bootPkg::Finish: begin
                    cpuReset <= 1'b0;
                    bootDone <= 1'b1;
                    state <= bootPkg::Run;
                end
                bootPkg::Run: begin
                    // Bus belongs to the CPU until the next reset
                end
                default: state <= bootPkg::Hold;
            endcase
        end
    end

    // Write payload
    always_ff @(posedge clk_25mhz) begin
        if (wordArrived) begin
            loadIndex <= ramIndex;
            loadData <= sdData;
        end
    end

    // Reader must be idle before a new request
    assert property (@(posedge clk_25mhz) disable iff (reset) sdRead |-> !sdBusy);

    // Loader writes never overlap CPU ownership
    assert property (@(posedge clk_25mhz) disable iff (reset) loadWrite |-> cpuReset);

endmodule

// File: design/bootPkg.sv
package bootPkg;

    // Loader sequence
    typedef enum logic [2:0] {
        Hold,
        ReadSize,
        WaitSize,
        ReadWord,
        WaitWord,
        Finish,
        Run
    } loaderStateT;

    // Global hold after reset before the SD card is touched
    localparam int ResetHoldCycles = 16;
    localparam int HoldCountBits = $clog2(ResetHoldCycles);

    // SD word address
    localparam int SdAddrBits = 32;

endpackage

// File: design/memMapPkg.sv
package memMapPkg;

    // Word and bank geometry
    localparam int WordBits = 32;
    localparam int NumBanks = 4;
    localparam int BankWords = 256;
    localparam int BankSelBits = 2;
    localparam int BankIndexBits = 8;

    // Word address into the whole RAM, bank bits at the bottom
    localparam int RamAddrBits = BankSelBits + BankIndexBits;

    // One CPU address with two decodes
    typedef union packed {
        // RAM word view, only valid when upper is zero
        struct packed {
            logic [15:0] upper;
            logic [15-RamAddrBits:0] spare;
            logic [BankIndexBits-1:0] index;
            logic [BankSelBits-1:0] bank;
        } mem;
        // Framebuffer view, only valid when low is zero
        struct packed {
            logic [7:0] y;
            logic [7:0] x;
            logic [15:0] low;
        } pixel;
    } cpuAddressT;

endpackage
